// File: project.f
source/csr_map_pkg.sv
source/csr_trap_pkg.sv
source/csr_access.sv
source/trap_control.sv
source/csr_update_arbiter.sv
source/csr_timer.sv
source/csr_file.sv
source/csr_unit.sv
bench/csr_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module csr_unit_tb -f project.f -o sim_csr_unit \
    || { echo "build failed"; exit 1; }
out="$(./obj_dir/sim_csr_unit)"
echo "$out"
echo "$out" | grep -qx "TEST PASSED" && exit 0 || exit 1

// File: bench/csr_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit_tb;

    import csr_map_pkg::*;
    import csr_trap_pkg::*;

    localparam int        CLK_PERIOD  = 100;
    localparam int        OP_CYCLES   = 4;
    localparam int        OP_COUNT    = 70;
    localparam csr_data_t TIMER_INIT  = 32'h0000_0010;
    localparam int        WAIT_CYCLES = 2 * 8 + 10 + TIMER_INIT + 8;
    localparam int        WATCHDOG_CYCLES = OP_COUNT * OP_CYCLES + WAIT_CYCLES + 100;

    logic        clk = 1'b0;
    logic        rstn;
    logic        stall;
    logic        flush;
    csr_req_t    req;
    excp_t       excp;
    logic [7:0]  hw_int;
    csr_data_t   rdata;
    redirect_t   redirect;
    crmd_t       crmd;
    logic        excp_flush;
    logic        ertn_flush;

    // scoreboard of the architectural registers
    csr_data_t   model [csr_num_t];
    csr_data_t   estat_live;
    csr_data_t   exp_target;
    crmd_t       exp_crmd;
    csr_data_t   next_pc;
    integer      seed;
    int          errors;
    int          errors_base;
    int          tests_run;
    logic        excp_acc;
    logic        ertn_acc;

    csr_unit i_csr_unit (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .flush      (flush),
        .req        (req),
        .excp       (excp),
        .hw_int     (hw_int),
        .rdata      (rdata),
        .redirect   (redirect),
        .crmd       (crmd),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign excp_acc = excp.valid && !stall && !flush;
    assign ertn_acc = req.valid && (req.op == ERTN) && !stall && !flush && !excp.valid;

    task automatic log_error(input string msg);
        errors++;
        $display("error %0t: %s", $time, msg);
    endtask

    reset_clears: assert property (@(posedge clk)
        !rstn |=> (!redirect.valid && !excp_flush && !ertn_flush && crmd == '0))
        else log_error("outputs not cleared by reset");

    excp_redirect: assert property (@(posedge clk) disable iff (!rstn)
        excp_acc |=> (redirect.valid && redirect.pc == exp_target))
        else log_error($sformatf("exception redirect pc 0x%08h, expected 0x%08h",
                                 redirect.pc, exp_target));

    excp_commit: assert property (@(posedge clk) disable iff (!rstn)
        $past(excp_acc, 2) |-> (excp_flush && crmd == exp_crmd))
        else log_error($sformatf("exception commit crmd 0x%01h, flush %0b", crmd, excp_flush));

    ertn_redirect: assert property (@(posedge clk) disable iff (!rstn)
        ertn_acc |=> (redirect.valid && redirect.pc == exp_target))
        else log_error($sformatf("ertn redirect pc 0x%08h, expected 0x%08h",
                                 redirect.pc, exp_target));

    ertn_commit: assert property (@(posedge clk) disable iff (!rstn)
        $past(ertn_acc, 2) |-> (ertn_flush && crmd == exp_crmd))
        else log_error($sformatf("ertn commit crmd 0x%01h, expected 0x%01h", crmd, exp_crmd));

    flush_follows_redirect: assert property (@(posedge clk) disable iff (!rstn)
        redirect.valid |=> (excp_flush || ertn_flush))
        else log_error("redirect not followed by a flush pulse");

    function automatic csr_data_t expect_read(input csr_num_t num);
        csr_data_t value;
        value = model.exists(num) ? model[num] : '0;
        case (num)
            ESTAT:   return value | estat_live;
            TICLR:   return '0;
            default: return value;
        endcase
    endfunction

    // each bit taken from the new data where its mask bit is set
    function automatic csr_data_t masked_merge(input csr_data_t old_val,
                                               input csr_data_t new_val,
                                               input csr_data_t mask);
        csr_data_t result;
        for (int b = 0; b < 32; b++)
            result[b] = mask[b] ? new_val[b] : old_val[b];
        return result;
    endfunction

    // writable fields only
    function automatic void apply_write(input csr_num_t num, input csr_data_t data);
        case (num)
            CRMD, PRMD: model[num] = data & 32'h0000_0007;
            ECFG:       model[num] = data & 32'h0000_0bff;
            ESTAT:      model[num] = (expect_read(ESTAT) & ~estat_live & ~32'h3) | (data & 32'h3);
            EENTRY:     model[num] = data & 32'hffff_ffc0;
            default:    model[num] = data;
        endcase
    endfunction

    function automatic void enter_trap_model(input ecode_e code, input logic [8:0] esub,
                                             input csr_data_t badv);
        csr_data_t swi;
        swi          = expect_read(ESTAT) & 32'h3;
        model[PRMD]  = expect_read(CRMD);
        model[CRMD]  = '0;
        model[ESTAT] = swi | {1'b0, esub, code, 16'b0};
        if (code == ADE || code == ALE)
            model[BADV] = badv;
    endfunction

    task automatic check_value(input csr_num_t num, input csr_data_t got, input csr_data_t exp);
        assert (got == exp)
        else
            log_error($sformatf("csr 0x%03h read 0x%08h, expected 0x%08h", num, got, exp));
    endtask

    task automatic run_csr_op(input csr_op_e op, input csr_num_t num, input csr_data_t wdata,
                              input csr_data_t wmask);
        csr_req_t  r;
        csr_data_t old_exp;
        r.valid = 1'b1;
        r.op    = op;
        r.num   = num;
        r.wdata = wdata;
        r.wmask = wmask;
        r.pc    = next_pc;
        next_pc = next_pc + 32'd4;
        old_exp = expect_read(num);
        @(posedge clk);
        req <= r;
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        check_value(num, rdata, old_exp);
        if (op == CSRWR)
            apply_write(num, wdata);
        else if (op == CSRXCHG)
            apply_write(num, masked_merge(old_exp, wdata, wmask));
        @(posedge clk);
        @(posedge clk);
    endtask

    task automatic stalled_write(input csr_num_t num, input csr_data_t data);
        csr_req_t  r;
        csr_data_t prev;
        r       = '0;
        r.valid = 1'b1;
        r.op    = CSRWR;
        r.num   = num;
        r.wdata = data;
        r.pc    = next_pc;
        @(negedge clk);
        prev = rdata;
        @(posedge clk);
        req   <= r;
        stall <= 1'b1;
        @(posedge clk);
        req   <= '0;
        stall <= 1'b0;
        @(negedge clk);
        assert (rdata == prev)
        else
            log_error("rdata changed for a request issued under stall");
        repeat (2) @(posedge clk);
        run_csr_op(CSRRD, num, '0, '0);
    endtask

    task automatic raise_exception(input ecode_e code, input logic [8:0] esub,
                                   input csr_data_t pc, input csr_data_t badv);
        excp_t     e;
        csr_data_t badv_exp;
        e.valid    = 1'b1;
        e.ecode    = code;
        e.esubcode = esub;
        e.badv     = badv;
        e.pc       = pc;
        // fetch address error reports the pc as the bad address
        badv_exp   = (code == ADE && esub == ESUB_ADEF) ? pc : badv;
        exp_target = expect_read(EENTRY);
        exp_crmd   = '0;
        @(posedge clk);
        excp <= e;
        @(posedge clk);
        excp <= '0;
        repeat (3) @(posedge clk);
        enter_trap_model(code, esub, badv_exp);
        model[ERA] = pc;
    endtask

    task automatic return_from_trap();
        csr_req_t  r;
        csr_data_t prmd_val;
        r          = '0;
        r.valid    = 1'b1;
        r.op       = ERTN;
        r.pc       = next_pc;
        prmd_val   = expect_read(PRMD);
        exp_target = expect_read(ERA);
        exp_crmd   = prmd_val[2:0];
        @(posedge clk);
        req <= r;
        @(posedge clk);
        req <= '0;
        repeat (3) @(posedge clk);
        model[CRMD] = prmd_val;
    endtask

    task automatic await_interrupt(input int max_cycles);
        int        n;
        logic      seen;
        csr_data_t target;
        n      = 0;
        seen   = 1'b0;
        target = '0;
        while (!seen && n < max_cycles)
        begin
            @(negedge clk);
            if (redirect.valid)
            begin
                seen   = 1'b1;
                target = redirect.pc;
            end
            n++;
        end
        if (!seen)
            log_error($sformatf("no interrupt redirect within %0d cycles", max_cycles));
        else
        begin
            assert (target == expect_read(EENTRY))
            else
                log_error($sformatf("interrupt redirect pc 0x%08h, expected 0x%08h",
                                    target, expect_read(EENTRY)));
            enter_trap_model(INT, 9'd0, '0);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic expect_no_redirect(input int cycles);
        int taken;
        taken = 0;
        repeat (cycles)
        begin
            @(negedge clk);
            if (redirect.valid)
                taken++;
        end
        assert (taken == 0)
        else
            log_error($sformatf("%0d interrupt redirects taken while IE was clear", taken));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - errors_base);
        errors_base = errors;
    endtask

    initial
    begin
        csr_num_t  plain_regs [0:5];
        csr_data_t data;
        csr_data_t mask;
        rstn        = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        req         = '0;
        excp        = '0;
        hw_int      = '0;
        estat_live  = '0;
        exp_target  = '0;
        exp_crmd    = '0;
        next_pc     = 32'h1c00_0000;
        seed        = 32'hfb29_ad29;
        errors      = 0;
        errors_base = 0;
        tests_run   = 0;
        plain_regs  = '{SAVE0, SAVE1, SAVE2, SAVE3, ERA, TID};
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        for (int i = 0; i < 6; i++)
        begin
            data = $random(seed);
            run_csr_op(CSRWR, plain_regs[i], data, '0);
        end
        for (int i = 0; i < 6; i++)
            run_csr_op(CSRRD, plain_regs[i], '0, '0);
        stalled_write(SAVE0, 32'h5a5a_0f0f);
        end_test("csrwr and csrrd");

        for (int i = 0; i < 4; i++)
        begin
            data = $random(seed);
            mask = $random(seed);
            run_csr_op(CSRXCHG, plain_regs[i], data, mask);
            run_csr_op(CSRRD, plain_regs[i], '0, '0);
        end
        data = $random(seed);
        run_csr_op(CSRWR, EENTRY, data, '0);
        run_csr_op(CSRRD, EENTRY, '0, '0);
        data = $random(seed);
        run_csr_op(CSRXCHG, EENTRY, data, 32'h0000_ffff);
        run_csr_op(CSRRD, EENTRY, '0, '0);
        end_test("csrxchg masking");

        // plv 3 with IE set, but no local interrupt enabled yet
        run_csr_op(CSRWR, CRMD, 32'h0000_0007, '0);
        raise_exception(SYS, 9'd0, 32'h1c00_2000, 32'h0bad_0000);
        run_csr_op(CSRRD, ESTAT, '0, '0);
        run_csr_op(CSRRD, ERA, '0, '0);
        run_csr_op(CSRRD, PRMD, '0, '0);
        run_csr_op(CSRRD, BADV, '0, '0);
        run_csr_op(CSRWR, CRMD, 32'h0000_0005, '0);
        raise_exception(ADE, ESUB_ADEF, 32'h1c00_3004, 32'h1234_5678);
        run_csr_op(CSRRD, ESTAT, '0, '0);
        run_csr_op(CSRRD, ERA, '0, '0);
        run_csr_op(CSRRD, PRMD, '0, '0);
        run_csr_op(CSRRD, BADV, '0, '0);
        end_test("exception entry");

        return_from_trap();
        run_csr_op(CSRRD, CRMD, '0, '0);
        end_test("ertn");

        // software interrupt 0
        run_csr_op(CSRWR, ECFG, 32'h0000_0001, '0);
        run_csr_op(CSRWR, ESTAT, 32'h0000_0001, '0);
        await_interrupt(8);
        run_csr_op(CSRRD, ESTAT, '0, '0);
        run_csr_op(CSRWR, ESTAT, '0, '0);
        // hardware line 0
        run_csr_op(CSRWR, CRMD, 32'h0000_0004, '0);
        run_csr_op(CSRWR, ECFG, 32'h0000_0004, '0);
        @(posedge clk);
        hw_int <= 8'h01;
        await_interrupt(8);
        expect_no_redirect(10);
        estat_live = 32'h0000_0004;
        run_csr_op(CSRRD, ESTAT, '0, '0);
        @(posedge clk);
        hw_int <= 8'h00;
        estat_live = '0;
        end_test("interrupt entry");

        run_csr_op(CSRWR, CRMD, 32'h0000_0004, '0);
        run_csr_op(CSRWR, ECFG, 32'h0000_0800, '0);
        // enabled, one-shot
        run_csr_op(CSRWR, TCFG, TIMER_INIT | 32'h1, '0);
        await_interrupt(TIMER_INIT + 8);
        estat_live = 32'h0000_0800;
        run_csr_op(CSRRD, ESTAT, '0, '0);
        run_csr_op(CSRWR, TICLR, 32'h0000_0001, '0);
        estat_live = '0;
        run_csr_op(CSRRD, ESTAT, '0, '0);
        end_test("timer interrupt");

        $display("tests %0d, errors %0d", tests_run, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    stall,
    input  logic                    flush,
    input  csr_trap_pkg::csr_req_t  req,
    input  csr_trap_pkg::excp_t     excp,
    input  logic [7:0]              hw_int,
    output csr_map_pkg::csr_data_t  rdata,
    output csr_trap_pkg::redirect_t redirect,
    output csr_map_pkg::crmd_t      crmd,
    output logic                    excp_flush,
    output logic                    ertn_flush
);

    import csr_map_pkg::*;
    import csr_trap_pkg::*;

    csr_num_t    rd_num;
    csr_data_t   rd_data;
    csr_update_t access_upd;
    csr_update_t trap_upd;
    csr_update_t granted_upd;
    int_status_t status;
    csr_data_t   era;
    csr_data_t   eentry;
    logic        ti;
    csr_data_t   tcfg;
    csr_data_t   tval;

    csr_access i_csr_access (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .flush      (flush),
        .req        (req),
        .rd_num     (rd_num),
        .rd_data    (rd_data),
        .access_upd (access_upd),
        .rdata      (rdata)
    );

    trap_control i_trap_control (
        .clk      (clk),
        .rstn     (rstn),
        .stall    (stall),
        .flush    (flush),
        .req      (req),
        .excp     (excp),
        .status   (status),
        .era      (era),
        .eentry   (eentry),
        .trap_upd (trap_upd),
        .redirect (redirect)
    );

    csr_update_arbiter i_csr_update_arbiter (
        .access_upd  (access_upd),
        .trap_upd    (trap_upd),
        .granted_upd (granted_upd)
    );

    csr_file i_csr_file (
        .clk        (clk),
        .rstn       (rstn),
        .upd        (granted_upd),
        .rd_num     (rd_num),
        .rd_data    (rd_data),
        .hw_int     (hw_int),
        .ti         (ti),
        .tcfg       (tcfg),
        .tval       (tval),
        .status     (status),
        .era        (era),
        .eentry     (eentry),
        .crmd       (crmd),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush)
    );

    csr_timer i_csr_timer (
        .clk  (clk),
        .rstn (rstn),
        .upd  (granted_upd),
        .ti   (ti),
        .tcfg (tcfg),
        .tval (tval)
    );

endmodule

`default_nettype wire

// File: source/csr_file.sv
`timescale 1ns/10ps
`default_nettype none

module csr_file (
    input  logic                      clk,
    input  logic                      rstn,
    input  csr_trap_pkg::csr_update_t upd,
    input  csr_map_pkg::csr_num_t     rd_num,
    output csr_map_pkg::csr_data_t    rd_data,
    input  logic [7:0]                hw_int,
    input  logic                      ti,
    input  csr_map_pkg::csr_data_t    tcfg,
    input  csr_map_pkg::csr_data_t    tval,
    output csr_map_pkg::int_status_t  status,
    output csr_map_pkg::csr_data_t    era,
    output csr_map_pkg::csr_data_t    eentry,
    output csr_map_pkg::crmd_t        crmd,
    output logic                      excp_flush,
    output logic                      ertn_flush
);

    import csr_map_pkg::*;
    import csr_trap_pkg::*;

    crmd_t            crmd_q;
    crmd_t            prmd_q;
    logic [LIE_W-1:0] lie_q;
    logic [1:0]       is_q;
    logic [5:0]       ecode_q;
    logic [8:0]       esub_q;
    csr_data_t        era_q;
    csr_data_t        badv_q;
    logic [25:0]      eentry_q;
    csr_data_t        save_q [0:3];
    csr_data_t        tid_q;
    csr_data_t        estat_word;

    always_comb
    begin
        estat_word         = '0;
        estat_word[1:0]    = is_q;
        estat_word[9:2]    = hw_int;
        estat_word[TI_BIT] = ti;
        estat_word[21:16]  = ecode_q;
        estat_word[30:22]  = esub_q;

        case (rd_num)
            CRMD:   rd_data = {29'b0, crmd_q};
            PRMD:   rd_data = {29'b0, prmd_q};
            ECFG:   rd_data = {20'b0, lie_q};
            ESTAT:  rd_data = estat_word;
            ERA:    rd_data = era_q;
            BADV:   rd_data = badv_q;
            EENTRY: rd_data = {eentry_q, 6'b0};
            SAVE0, SAVE1, SAVE2, SAVE3:
                rd_data = save_q[rd_num[1:0]];
            TID:    rd_data = tid_q;
            TCFG:   rd_data = tcfg;
            TVAL:   rd_data = tval;
            // TICLR and unknown numbers read zero
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd_q   <= '0;
            prmd_q   <= '0;
            lie_q    <= '0;
            is_q     <= '0;
            ecode_q  <= '0;
            esub_q   <= '0;
            era_q    <= '0;
            badv_q   <= '0;
            eentry_q <= '0;
            tid_q    <= '0;
            for (int i = 0; i < 4; i++)
                save_q[i] <= '0;
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
            case (upd.kind)
                UPD_WRITE:
                    case (upd.num)
                        CRMD:
                        begin
                            crmd_q.plv <= upd.data[PLV_W-1:0];
                            crmd_q.ie  <= upd.data[IE_BIT];
                        end
                        PRMD:
                        begin
                            prmd_q.plv <= upd.data[PLV_W-1:0];
                            prmd_q.ie  <= upd.data[IE_BIT];
                        end
                        ECFG:   lie_q <= {upd.data[11], 1'b0, upd.data[9:0]};
                        // only the software interrupt bits are writable
                        ESTAT:  is_q <= upd.data[1:0];
                        ERA:    era_q <= upd.data;
                        BADV:   badv_q <= upd.data;
                        EENTRY: eentry_q <= upd.data[31:6];
                        SAVE0, SAVE1, SAVE2, SAVE3:
                            save_q[upd.num[1:0]] <= upd.data;
                        TID:    tid_q <= upd.data;
                        default: ;
                    endcase
                UPD_TRAP:
                begin
                    prmd_q  <= crmd_q;
                    crmd_q  <= '0;
                    era_q   <= upd.era;
                    ecode_q <= upd.ecode;
                    esub_q  <= upd.esubcode;
                    if (upd.ecode == ADE || upd.ecode == ALE)
                        badv_q <= upd.badv;
                    excp_flush <= 1'b1;
                end
                UPD_ERTN:
                begin
                    crmd_q     <= prmd_q;
                    ertn_flush <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_comb
    begin
        status.swi = is_q;
        status.hwi = hw_int;
        status.ti  = ti;
        status.lie = lie_q;
        status.ie  = crmd_q.ie;
    end

    assign era    = era_q;
    assign eentry = {eentry_q, 6'b0};
    assign crmd   = crmd_q;

endmodule

`default_nettype wire

// File: source/csr_timer.sv
`timescale 1ns/10ps
`default_nettype none

module csr_timer (
    input  logic                      clk,
    input  logic                      rstn,
    input  csr_trap_pkg::csr_update_t upd,
    output logic                      ti,
    output csr_map_pkg::csr_data_t    tcfg,
    output csr_map_pkg::csr_data_t    tval
);

    import csr_map_pkg::*;
    import csr_trap_pkg::*;

    csr_data_t tcfg_q;
    csr_data_t tval_q;
    logic      ti_q;
    logic      tcfg_wr;
    logic      ticlr_wr;

    assign tcfg_wr  = (upd.kind == UPD_WRITE) && (upd.num == TCFG);
    assign ticlr_wr = (upd.kind == UPD_WRITE) && (upd.num == TICLR) && upd.data[0];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg_q <= '0;
            tval_q <= '0;
            ti_q   <= 1'b0;
        end
        else
        begin
            if (tcfg_wr)
            begin
                tcfg_q <= upd.data;
                tval_q <= {upd.data[31:2], 2'b00};
            end
            else if (tcfg_q[0] && tval_q != '0)
            begin
                // periodic mode reloads instead of stopping at zero
                if (tval_q == 32'd1 && tcfg_q[1])
                    tval_q <= {tcfg_q[31:2], 2'b00};
                else
                    tval_q <= tval_q - 32'd1;
            end

            if (ticlr_wr)
                ti_q <= 1'b0;
            else if (!tcfg_wr && tcfg_q[0] && tval_q == 32'd1)
                ti_q <= 1'b1;
        end
    end

    assign ti   = ti_q;
    assign tcfg = tcfg_q;
    assign tval = tval_q;

endmodule

`default_nettype wire

// File: source/csr_update_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module csr_update_arbiter (
    input  csr_trap_pkg::csr_update_t access_upd,
    input  csr_trap_pkg::csr_update_t trap_upd,
    output csr_trap_pkg::csr_update_t granted_upd
);

    import csr_trap_pkg::*;

    logic trap_valid;

    assign trap_valid = (trap_upd.kind != UPD_NONE);

    // trap path always wins
    // a write cancelled by an interrupt is lost here
    always_comb
    begin
        if (trap_valid)
            granted_upd = trap_upd;
        else
            granted_upd = access_upd;

        assert (!(trap_valid && granted_upd.kind == UPD_WRITE))
            else $error("csr write granted in a trap cycle");
    end

endmodule

`default_nettype wire

// File: source/trap_control.sv
`timescale 1ns/10ps
`default_nettype none

module trap_control (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      stall,
    input  logic                      flush,
    input  csr_trap_pkg::csr_req_t    req,
    input  csr_trap_pkg::excp_t       excp,
    input  csr_map_pkg::int_status_t  status,
    input  csr_map_pkg::csr_data_t    era,
    input  csr_map_pkg::csr_data_t    eentry,
    output csr_trap_pkg::csr_update_t trap_upd,
    output csr_trap_pkg::redirect_t   redirect
);

    import csr_map_pkg::*;
    import csr_trap_pkg::*;

    logic [LIE_W-1:0] int_vec;
    logic             int_block;
    logic             take_int;
    logic             take_excp;
    logic             take_ertn;
    update_kind_e     kind_d;
    update_kind_e     kind_q;
    ecode_e           ecode_d;
    ecode_e           ecode_q;
    logic [8:0]       esub_d;
    logic [8:0]       esub_q;
    csr_data_t        badv_d;
    csr_data_t        badv_q;
    csr_data_t        era_d;
    csr_data_t        era_q;
    csr_data_t        target_d;
    csr_data_t        target_q;
    logic             redir_valid_q;

    // bit 10 has no source
    assign int_vec = {status.ti, 1'b0, status.hwi, status.swi};

    // IE is still set in the cycle after an interrupt is taken
    assign take_int  = status.ie && |(int_vec & status.lie) && !int_block;
    assign take_excp = excp.valid && !stall && !flush && !take_int;
    assign take_ertn = req.valid && (req.op == ERTN) && !stall && !flush
                       && !take_int && !excp.valid;

    always_comb
    begin
        kind_d   = UPD_NONE;
        ecode_d  = INT;
        esub_d   = '0;
        badv_d   = excp.badv;
        era_d    = req.pc;
        target_d = eentry;
        if (take_int)
        begin
            kind_d = UPD_TRAP;
            era_d  = excp.valid ? excp.pc : req.pc;
        end
        else if (take_excp)
        begin
            kind_d  = UPD_TRAP;
            ecode_d = excp.ecode;
            esub_d  = excp.esubcode;
            era_d   = excp.pc;
            // fetch address error reports the pc itself
            if (excp.ecode == ADE && excp.esubcode == ESUB_ADEF)
                badv_d = excp.pc;
        end
        else if (take_ertn)
        begin
            kind_d   = UPD_ERTN;
            target_d = era;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            kind_q        <= UPD_NONE;
            redir_valid_q <= 1'b0;
            int_block     <= 1'b0;
        end
        else
        begin
            kind_q        <= kind_d;
            redir_valid_q <= (kind_d != UPD_NONE);
            int_block     <= take_int;
        end
    end

    always_ff @(posedge clk)
    begin
        ecode_q  <= ecode_d;
        esub_q   <= esub_d;
        badv_q   <= badv_d;
        era_q    <= era_d;
        target_q <= target_d;
    end

    always_comb
    begin
        trap_upd          = '0;
        trap_upd.kind     = kind_q;
        trap_upd.ecode    = ecode_q;
        trap_upd.esubcode = esub_q;
        trap_upd.badv     = badv_q;
        trap_upd.era      = era_q;
        redirect.valid    = redir_valid_q;
        redirect.pc       = target_q;
    end

    redirect_has_update: assert property (@(posedge clk) disable iff (!rstn)
        redirect.valid |-> (trap_upd.kind != UPD_NONE));

endmodule

`default_nettype wire

// File: source/csr_access.sv
`timescale 1ns/10ps
`default_nettype none

module csr_access (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      stall,
    input  logic                      flush,
    input  csr_trap_pkg::csr_req_t    req,
    output csr_map_pkg::csr_num_t     rd_num,
    input  csr_map_pkg::csr_data_t    rd_data,
    output csr_trap_pkg::csr_update_t access_upd,
    output csr_map_pkg::csr_data_t    rdata
);

    import csr_map_pkg::*;
    import csr_trap_pkg::*;

    logic         is_write_op;
    logic         is_csr_op;
    logic         accept;
    csr_data_t    wmask;
    csr_data_t    merged;
    update_kind_e upd_kind;
    csr_num_t     upd_num;
    csr_data_t    upd_data;
    csr_data_t    rdata_q;

    assign rd_num = req.num;

    assign is_write_op = (req.op == CSRWR) || (req.op == CSRXCHG);
    assign is_csr_op   = is_write_op || (req.op == CSRRD);
    assign accept      = req.valid && !stall && !flush && is_csr_op;

    // csrwr replaces the whole word
    assign wmask  = (req.op == CSRWR) ? '1 : req.wmask;
    assign merged = (rd_data & ~wmask) | (req.wdata & wmask);

    always_ff @(posedge clk)
    begin
        if (!rstn)
            upd_kind <= UPD_NONE;
        else if (accept && is_write_op)
            upd_kind <= UPD_WRITE;
        else
            upd_kind <= UPD_NONE;
    end

    // old value and write data held until the next accepted request
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            rdata_q  <= rd_data;
            upd_num  <= req.num;
            upd_data <= merged;
        end
    end

    always_comb
    begin
        access_upd      = '0;
        access_upd.kind = upd_kind;
        access_upd.num  = upd_num;
        access_upd.data = upd_data;
    end

    assign rdata = rdata_q;

endmodule

`default_nettype wire

// File: source/csr_trap_pkg.sv
`default_nettype none

package csr_trap_pkg;

    typedef enum logic [2:0] {
        NOP,
        CSRRD,
        CSRWR,
        CSRXCHG,
        ERTN
    } csr_op_e;

    typedef enum logic [5:0] {
        INT = 6'h00,
        ADE = 6'h08,
        ALE = 6'h09,
        SYS = 6'h0b,
        BRK = 6'h0c,
        INE = 6'h0d,
        IPE = 6'h0e
    } ecode_e;

    localparam logic [8:0] ESUB_ADEF = 9'd0;

    typedef struct packed {
        logic                   valid;
        csr_op_e                op;
        csr_map_pkg::csr_num_t  num;
        csr_map_pkg::csr_data_t wdata;
        csr_map_pkg::csr_data_t wmask;
        csr_map_pkg::csr_data_t pc;
    } csr_req_t;

    typedef struct packed {
        logic                   valid;
        ecode_e                 ecode;
        logic [8:0]             esubcode;
        csr_map_pkg::csr_data_t badv;
        csr_map_pkg::csr_data_t pc;
    } excp_t;

    typedef enum logic [1:0] {
        UPD_NONE,
        UPD_WRITE,
        UPD_TRAP,
        UPD_ERTN
    } update_kind_e;

    typedef struct packed {
        update_kind_e           kind;
        csr_map_pkg::csr_num_t  num;
        csr_map_pkg::csr_data_t data;
        ecode_e                 ecode;
        logic [8:0]             esubcode;
        csr_map_pkg::csr_data_t badv;
        csr_map_pkg::csr_data_t era;
    } csr_update_t;

    typedef struct packed {
        logic                   valid;
        csr_map_pkg::csr_data_t pc;
    } redirect_t;

endpackage

`default_nettype wire

// File: source/csr_map_pkg.sv
`default_nettype none

package csr_map_pkg;

    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] csr_data_t;

    // csr numbers kept by this core
    localparam csr_num_t CRMD   = 14'h000;
    localparam csr_num_t PRMD   = 14'h001;
    localparam csr_num_t ECFG   = 14'h004;
    localparam csr_num_t ESTAT  = 14'h005;
    localparam csr_num_t ERA    = 14'h006;
    localparam csr_num_t BADV   = 14'h007;
    localparam csr_num_t EENTRY = 14'h00c;
    localparam csr_num_t SAVE0  = 14'h030;
    localparam csr_num_t SAVE1  = 14'h031;
    localparam csr_num_t SAVE2  = 14'h032;
    localparam csr_num_t SAVE3  = 14'h033;
    localparam csr_num_t TID    = 14'h040;
    localparam csr_num_t TCFG   = 14'h041;
    localparam csr_num_t TVAL   = 14'h042;
    localparam csr_num_t TICLR  = 14'h044;

    localparam int IE_BIT = 2;
    localparam int PLV_W  = 2;
    localparam int TI_BIT = 11;
    localparam int LIE_W  = 12;

    // matches the low bits of the CRMD word
    typedef struct packed {
        logic             ie;
        logic [PLV_W-1:0] plv;
    } crmd_t;

    typedef struct packed {
        logic [1:0]       swi;
        logic [7:0]       hwi;
        logic             ti;
        logic [LIE_W-1:0] lie;
        logic             ie;
    } int_status_t;

endpackage

`default_nettype wire
